/* flacPkg.sv */
package flacPkg;

        // Fixed predictor order as carried in the subframe header, 0 to 4
        typedef logic [2:0] orderT;

        // Rice parameter of the residual section, 0 to 30
        typedef logic [4:0] riceParamT;

        // Number of inter-channel samples in one block
        typedef logic [15:0] blockSizeT;

        // Controller phases of one subframe
        // stWarmup takes raw words, stResidual takes Rice-coded residuals
        typedef enum logic [1:0] {
                stIdle,
                stWarmup,
                stResidual
        } ctrlStateT;

        // Highest fixed predictor order and so the depth of the sample history
        localparam int unsigned maxOrder = 4;

endpackage

/* bitReader.sv */
module bitReader
        import flacPkg::*;
#(
        parameter int SampleWidth = 16,
        parameter int AccWidth = 32
) (
        input  logic                       iClock,
        input  logic                       arstN,
        input  logic                       iBit,
        input  logic                       iBitValid,
        input  logic                       rawMode,
        input  riceParamT                  riceParam,
        output logic signed [AccWidth-1:0] value,
        output logic                       valueValid
);

        // Counter must reach the longer of a raw word and a Rice remainder
        localparam int CountWidth = $clog2(AccWidth + 1);

        // High while the low bits of a Rice code are shifting in
        logic inRemainder;
        logic [CountWidth-1:0] bitCount;
        logic [AccWidth-1:0] shiftReg;
        logic [AccWidth-1:0] shiftNext;
        logic [AccWidth-1:0] quotient;
        logic [AccWidth-1:0] folded;
        logic signed [AccWidth-1:0] rawWord;
        logic signed [AccWidth-1:0] riceWord;
        logic lastRawBit;
        logic lastRemBit;
        logic rawDone;
        logic riceDone;

        // Bits arrive MSB first, so each new bit enters at the bottom
        assign shiftNext = {shiftReg[AccWidth-2:0], iBit};

        // Warm-up words are two's complement and get sign-extended to AccWidth
        assign rawWord = $signed(shiftNext[SampleWidth-1:0]);

        assign lastRawBit = (bitCount == CountWidth'(SampleWidth - 1));
        assign lastRemBit = (bitCount == CountWidth'(riceParam) - 1'b1);

        // With a parameter of 0 the terminating one already ends the code
        assign folded = inRemainder ? ((quotient << riceParam) | shiftNext) : quotient;

        // Zigzag unfold: even codes are n/2, odd codes are -(n/2)-1
        assign riceWord = folded[0] ? ~(folded >> 1) : (folded >> 1);

        assign rawDone = iBitValid && rawMode && lastRawBit;
        assign riceDone = iBitValid && !rawMode &&
                (inRemainder ? lastRemBit : (iBit && (riceParam == '0)));

        always_ff @(posedge iClock or negedge arstN) begin
                if (!arstN) begin
                        inRemainder <= 1'b0;
                        bitCount    <= '0;
                        shiftReg    <= '0;
                        quotient    <= '0;
                        valueValid  <= 1'b0;
                end else begin
                        valueValid <= rawDone || riceDone;
                        if (rawDone || riceDone) begin
                                // Word complete, so the next one starts from a clean slate
                                inRemainder <= 1'b0;
                                bitCount    <= '0;
                                shiftReg    <= '0;
                                quotient    <= '0;
                        end else if (iBitValid) begin
                                if (rawMode || inRemainder) begin
                                        bitCount <= bitCount + 1'b1;
                                        shiftReg <= shiftNext;
                                end else if (!iBit) begin
                                        // Unary part, every zero adds one to the quotient
                                        quotient <= quotient + 1'b1;
                                end else begin
                                        // Stop bit seen and low bits follow
                                        inRemainder <= 1'b1;
                                        bitCount    <= '0;
                                end
                        end
                end
        end

        // Output word, only loaded when a word completes
        always_ff @(posedge iClock) begin
                if (rawDone) begin
                        value <= rawWord;
                end else if (riceDone) begin
                        value <= riceWord;
                end
        end

endmodule

/* fixedDecoder.sv */
module fixedDecoder
        import flacPkg::*;
#(
        parameter int AccWidth = 32
) (
        input  logic                       iClock,
        input  logic                       arstN,
        input  logic                       predEnable,
        input  logic                       predWarmup,
        input  orderT                      order,
        input  logic signed [AccWidth-1:0] value,
        output logic signed [AccWidth-1:0] oSample,
        output logic                       oSampleValid
);

        // history[0] is the newest reconstructed sample
        logic signed [AccWidth-1:0] history [maxOrder];
        logic signed [AccWidth-1:0] prediction;
        logic signed [AccWidth-1:0] newSample;

        // Binomial predictors of the FLAC fixed subframe
        always_comb begin
                case (order)
                        3'd0: prediction = '0;
                        3'd1: prediction = history[0];
                        3'd2: prediction = 2 * history[0] - history[1];
                        3'd3: prediction = 3 * history[0] - 3 * history[1] + history[2];
                        default: begin
                                prediction = 4 * history[0] - 6 * history[1]
                                        + 4 * history[2] - history[3];
                        end
                endcase
        end

        // Warm-up words are samples already and bypass the predictor
        assign newSample = predWarmup ? value : value + prediction;

        always_ff @(posedge iClock or negedge arstN) begin
                if (!arstN) begin
                        for (int i = 0; i < maxOrder; i++) begin
                                history[i] <= '0;
                        end
                        oSampleValid <= 1'b0;
                end else begin
                        oSampleValid <= predEnable;
                        if (predEnable) begin
                                // Oldest entry falls off the end
                                for (int i = maxOrder - 1; i > 0; i--) begin
                                        history[i] <= history[i-1];
                                end
                                history[0] <= newSample;
                        end
                end
        end

        // The newest history entry doubles as the output register
        assign oSample = history[0];

endmodule

/* subframeControl.sv */
module subframeControl
        import flacPkg::*;
(
        input  logic      iClock,
        input  logic      arstN,
        input  logic      iStart,
        input  orderT     iOrder,
        input  riceParamT iRiceParam,
        input  blockSizeT iBlockSize,
        input  logic      valueValid,
        output logic      rawMode,
        output riceParamT riceParam,
        output orderT     order,
        output logic      predEnable,
        output logic      predWarmup,
        output logic      oDone,
        output logic      oBusy
);

        ctrlStateT state;
        orderT orderReg;
        orderT orderIn;
        riceParamT riceReg;
        blockSizeT blockReg;
        // Values taken so far in the current block
        blockSizeT count;
        blockSizeT countNext;
        logic doneReg;
        logic accept;
        logic lastValue;
        logic lastWarmup;

        // A start is only honoured between blocks
        assign accept = iStart && (state == stIdle);

        // Orders above the history depth are not legal and get clamped
        assign orderIn = (iOrder > maxOrder) ? orderT'(maxOrder) : iOrder;

        assign countNext = count + 1'b1;
        assign lastValue = valueValid && (state != stIdle) && (countNext >= blockReg);
        assign lastWarmup = valueValid && (state == stWarmup) &&
                (countNext == blockSizeT'(orderReg));

        // Raw mode drops in the same cycle as the last warm-up value
        // so a residual bit right behind it is already read as Rice code
        assign rawMode = (state == stWarmup) && !lastWarmup;

        assign predEnable = valueValid && (state != stIdle);
        assign predWarmup = (state == stWarmup);
        assign riceParam = riceReg;
        assign order = orderReg;
        assign oDone = doneReg;

        // Busy stays up through the cycle that carries the final sample
        assign oBusy = (state != stIdle) || doneReg;

        always_ff @(posedge iClock or negedge arstN) begin
                if (!arstN) begin
                        state    <= stIdle;
                        orderReg <= '0;
                        riceReg  <= '0;
                        blockReg <= '0;
                        count    <= '0;
                        doneReg  <= 1'b0;
                end else begin
                        // Registered to line up with the predictor output
                        doneReg <= lastValue;
                        if (accept) begin
                                orderReg <= orderIn;
                                riceReg  <= iRiceParam;
                                blockReg <= iBlockSize;
                                count    <= '0;
                                state    <= (orderIn == '0) ? stResidual : stWarmup;
                        end else if (predEnable) begin
                                count <= countNext;
                                if (lastValue) begin
                                        state <= stIdle;
                                end else if (lastWarmup) begin
                                        state <= stResidual;
                                end
                        end
                end
        end

endmodule

/* flacSubframe.sv */
module flacSubframe
        import flacPkg::*;
#(
        parameter int SampleWidth = 16,
        parameter int AccWidth = 32
) (
        input  logic                       iClock,
        input  logic                       arstN,
        input  logic                       iStart,
        input  orderT                      iOrder,
        input  riceParamT                  iRiceParam,
        input  blockSizeT                  iBlockSize,
        input  logic                       iBit,
        input  logic                       iBitValid,
        output logic signed [AccWidth-1:0] oSample,
        output logic                       oSampleValid,
        output logic                       oDone,
        output logic                       oBusy
);

        logic rawMode;
        riceParamT riceParam;
        orderT order;
        logic signed [AccWidth-1:0] value;
        logic valueValid;
        logic predEnable;
        logic predWarmup;

        // Serial bits to warm-up words and residuals
        bitReader #(
                .SampleWidth(SampleWidth),
                .AccWidth   (AccWidth)
        ) reader (
                .iClock    (iClock),
                .arstN     (arstN),
                .iBit      (iBit),
                .iBitValid (iBitValid),
                .rawMode   (rawMode),
                .riceParam (riceParam),
                .value     (value),
                .valueValid(valueValid)
        );

        subframeControl control (
                .iClock    (iClock),
                .arstN     (arstN),
                .iStart    (iStart),
                .iOrder    (iOrder),
                .iRiceParam(iRiceParam),
                .iBlockSize(iBlockSize),
                .valueValid(valueValid),
                .rawMode   (rawMode),
                .riceParam (riceParam),
                .order     (order),
                .predEnable(predEnable),
                .predWarmup(predWarmup),
                .oDone     (oDone),
                .oBusy     (oBusy)
        );

        // Residuals back to PCM samples
        fixedDecoder #(
                .AccWidth(AccWidth)
        ) predictor (
                .iClock      (iClock),
                .arstN       (arstN),
                .predEnable  (predEnable),
                .predWarmup  (predWarmup),
                .order       (order),
                .value       (value),
                .oSample     (oSample),
                .oSampleValid(oSampleValid)
        );

endmodule

/* tbClock.sv */
module tbClock (
        output logic iClock,
        output logic arstN
);
        timeunit 1ns;
        timeprecision 1ps;

        // 40 ns period with the first rising edge at 20 ns
        localparam int HalfPeriod = 20;
        localparam int ResetCycles = 8;

        initial begin
                iClock = 1'b0;
                forever #(HalfPeriod) iClock = ~iClock;
        end

        // Release on a falling edge so the first active edge sees a settled reset
        initial begin
                arstN = 1'b0;
                repeat (ResetCycles) @(posedge iClock);
                @(negedge iClock);
                arstN = 1'b1;
        end

endmodule

/* flacSubframe_asserts.sv */
module flacSubframe_asserts
        import flacPkg::*;
#(
        parameter int AccWidth = 32
) (
        input logic                       iClock,
        input logic                       arstN,
        input logic                       iStart,
        input orderT                      order,
        input logic signed [AccWidth-1:0] oSample,
        input logic                       oSampleValid,
        input logic                       oDone,
        input logic                       oBusy
);
        timeunit 1ns;
        timeprecision 1ps;

        // Number of assertion failures, read by the testbench at the end of the run
        int failCount = 0;

        doneWithSample: assert property (@(posedge iClock) disable iff (!arstN)
                oDone |-> oSampleValid)
                else begin
                        failCount++;
                        $error("Done pulse without a sample valid");
                end

        // A sample may only leave while a block is in progress
        validWhileBusy: assert property (@(posedge iClock) disable iff (!arstN)
                oSampleValid |-> oBusy)
                else begin
                        failCount++;
                        $error("Sample valid while not busy");
                end

        // With oDone low a busy controller is mid-block and must ignore a start
        startIgnored: assert property (@(posedge iClock) disable iff (!arstN)
                (iStart && oBusy && !oDone) |=> $stable(order))
                else begin
                        failCount++;
                        $error("Start during a block changed the latched order");
                end

        resetOutputs: assert property (@(posedge iClock)
                $rose(arstN) |-> (!oSampleValid && !oDone && !oBusy && oSample == '0))
                else begin
                        failCount++;
                        $error("Outputs not cleared by reset");
                end

endmodule

/* tbFlacSubframe.sv */
module tbFlacSubframe
        import flacPkg::*;
();
        timeunit 1ns;
        timeprecision 1ps;

        localparam int SampleWidth = 16;
        localparam int AccWidth = 32;
        // Generous bit budget per block, two cycles per bit, 40 ns per cycle
        localparam int NumBlocks = 14;
        localparam int MaxBlockBits = 1200;
        localparam int WatchdogTime = NumBlocks * MaxBlockBits * 2 * 40 + 20000;

        logic iClock;
        logic arstN;
        logic iStart;
        orderT iOrder;
        riceParamT iRiceParam;
        blockSizeT iBlockSize;
        logic iBit;
        logic iBitValid;
        logic signed [AccWidth-1:0] oSample;
        logic oSampleValid;
        logic oDone;
        logic oBusy;

        // Reference signal of the current block and its serialized subframe body
        int signal[$];
        bit bits[$];
        logic signed [AccWidth-1:0] gotSamples[$];
        int doneCount;
        int countAtDone;
        int unsigned lcgState = 11;

        tbClock clockGen (
                .iClock(iClock),
                .arstN (arstN)
        );

        flacSubframe #(
                .SampleWidth(SampleWidth),
                .AccWidth   (AccWidth)
        ) UUT (
                .iClock      (iClock),
                .arstN       (arstN),
                .iStart      (iStart),
                .iOrder      (iOrder),
                .iRiceParam  (iRiceParam),
                .iBlockSize  (iBlockSize),
                .iBit        (iBit),
                .iBitValid   (iBitValid),
                .oSample     (oSample),
                .oSampleValid(oSampleValid),
                .oDone       (oDone),
                .oBusy       (oBusy)
        );

        bind flacSubframe flacSubframe_asserts #(.AccWidth(AccWidth)) protocolChecks (.*);

        function automatic int unsigned lcgNext();
                lcgState = lcgState * 32'd1103515245 + 32'd12345;
                return lcgState >> 8;
        endfunction

        // Uniform value in -limit to limit
        function automatic int randSigned(input int limit);
                return int'(lcgNext() % (2 * limit + 1)) - limit;
        endfunction

        // Order-th backward difference at sample n, which is what the encoder transmits
        function automatic int residualAt(input int n, input int order);
                int d[5];
                for (int i = 0; i <= order; i++) begin
                        d[i] = signal[n - order + i];
                end
                for (int level = 0; level < order; level++) begin
                        for (int i = 0; i < order - level; i++) begin
                                d[i] = d[i + 1] - d[i];
                        end
                end
                return d[0];
        endfunction

        task automatic abortRun();
                $display("TEST FAILED");
                $fatal(1, "Stopped at the first error");
        endtask

        task automatic checkSample(input logic signed [AccWidth-1:0] got,
                        input logic signed [AccWidth-1:0] expected, input int index);
                if (got !== expected) begin
                        $display("FAILED at %0t: sample %0d is %0d, expected %0d",
                                $time, index, got, expected);
                        abortRun();
                end
        endtask

        task automatic checkCount(input blockSizeT got, input blockSizeT expected,
                        input string what);
                if (got !== expected) begin
                        $display("FAILED at %0t: %s is %0d, expected %0d",
                                $time, what, got, expected);
                        abortRun();
                end
        endtask

        // Warm-up words go out raw, residuals as unary quotient, stop bit, k low bits
        task automatic encodeBlock(input int order, input int k);
                int r;
                int unsigned fold;
                bits.delete();
                for (int n = 0; n < signal.size(); n++) begin
                        if (n < order) begin
                                for (int b = SampleWidth - 1; b >= 0; b--) begin
                                        bits.push_back(signal[n][b]);
                                end
                        end else begin
                                r = residualAt(n, order);
                                fold = (r >= 0) ? 2 * r : -2 * r - 1;
                                repeat (fold >> k) bits.push_back(1'b0);
                                bits.push_back(1'b1);
                                for (int b = k - 1; b >= 0; b--) begin
                                        bits.push_back(fold[b]);
                                end
                        end
                end
        endtask

        // Signal with a slowly drifting slope so that higher orders see small residuals
        task automatic makeSmooth(input int size);
                int slope;
                signal.delete();
                signal.push_back(randSigned(1000));
                slope = randSigned(6);
                for (int n = 1; n < size; n++) begin
                        slope += randSigned(2);
                        signal.push_back(signal[n - 1] + slope);
                end
        endtask

        task automatic runBlock(input int order, input int k, input bit gapped,
                        input bit midStart);
                blockSizeT size;
                size = blockSizeT'(signal.size());
                encodeBlock(order, k);
                gotSamples.delete();
                doneCount = 0;
                iOrder = orderT'(order);
                iRiceParam = riceParamT'(k);
                iBlockSize = size;
                iStart = 1'b1;
                @(negedge iClock);
                iStart = 1'b0;
                foreach (bits[i]) begin
                        while (gapped && lcgNext() % 4 == 0) begin
                                iBitValid = 1'b0;
                                @(negedge iClock);
                        end
                        // A second start halfway through must leave the block untouched
                        iStart = midStart && (i == bits.size() / 2);
                        if (iStart) begin
                                iOrder = '0;
                        end
                        iBit = bits[i];
                        iBitValid = 1'b1;
                        @(negedge iClock);
                end
                iBitValid = 1'b0;
                iStart = 1'b0;
                for (int c = 0; c < 64 && doneCount == 0; c++) begin
                        @(posedge iClock);
                end
                if (doneCount == 0) begin
                        $display("No done pulse within 64 cycles of the last bit");
                        abortRun();
                end
                @(negedge iClock);
                if (oBusy) begin
                        $display("FAILED at %0t: busy still high in the cycle after the done pulse",
                                $time);
                        abortRun();
                end
                repeat (4) @(negedge iClock);
                checkCount(blockSizeT'(doneCount), 1, "done pulses in block");
                checkCount(blockSizeT'(countAtDone), size, "samples up to done");
                checkCount(blockSizeT'(gotSamples.size()), size, "samples in block");
                foreach (signal[i]) begin
                        checkSample(gotSamples[i], AccWidth'(signal[i]), i);
                end
        endtask

        // Order 0 with parameter 0, so every residual is the sample itself
        task automatic testOrderZero();
                signal.delete();
                for (int n = 0; n < 16; n++) begin
                        signal.push_back(randSigned(20));
                end
                runBlock(0, 0, 0, 0);
        endtask

        // Each stream runs once back to back and once with gaps in iBitValid
        task automatic testSmoothOrders();
                for (int order = 1; order <= 4; order++) begin
                        makeSmooth(32);
                        runBlock(order, 3, 0, 0);
                        runBlock(order, 3, 1, 0);
                end
        endtask

        task automatic testZigzag(input int k, input int order);
                int big;
                int residuals[$];
                big = 15 << k;
                residuals = '{-1, 0, 1, -big, big - 1, big, -2, 2};
                signal.delete();
                if (order == 1) begin
                        signal.push_back(-321);
                end
                foreach (residuals[i]) begin
                        if (order == 1) begin
                                signal.push_back(signal[signal.size() - 1] + residuals[i]);
                        end else begin
                                signal.push_back(residuals[i]);
                        end
                end
                runBlock(order, k, 0, 0);
        endtask

        // Mid-block start, then a block shorter than its order
        task automatic testStartIgnored();
                makeSmooth(24);
                runBlock(2, 3, 0, 1);
                makeSmooth(2);
                runBlock(4, 3, 0, 0);
        endtask

        // Outputs are registered at the rising edge so the falling edge sees them settled
        always @(negedge iClock) begin
                if (arstN && oSampleValid) begin
                        gotSamples.push_back(oSample);
                        if (oDone) begin
                                doneCount++;
                                countAtDone = gotSamples.size();
                        end
                end
        end

        always @(UUT.protocolChecks.failCount) begin
                if (UUT.protocolChecks.failCount != 0) begin
                        $display("A protocol assertion fired during the run");
                        abortRun();
                end
        end

        initial begin
                #(WatchdogTime);
                $display("Watchdog expired before the tests finished");
                abortRun();
        end

        initial begin
                iStart = 1'b0;
                iOrder = '0;
                iRiceParam = '0;
                iBlockSize = '0;
                iBit = 1'b0;
                iBitValid = 1'b0;
                doneCount = 0;
                countAtDone = 0;
                wait (arstN === 1'b1);
                @(negedge iClock);
                testOrderZero();
                testSmoothOrders();
                testZigzag(0, 0);
                testZigzag(1, 0);
                testZigzag(12, 1);
                testStartIgnored();
                if (UUT.protocolChecks.failCount == 0) begin
                        $display("TEST OK");
                        $finish;
                end else begin
                        $display("TEST FAILED");
                        $fatal(1, "Protocol assertions reported errors");
                end
        end

endmodule

/* src.f */
flacPkg.sv
bitReader.sv
fixedDecoder.sv
subframeControl.sv
flacSubframe.sv
tbClock.sv
flacSubframe_asserts.sv
tbFlacSubframe.sv

/* Bender.yml */
package:
  name: flac_subframe

sources:
  - flacPkg.sv
  - bitReader.sv
  - fixedDecoder.sv
  - subframeControl.sv
  - flacSubframe.sv
  - target: test
    files:
      - tbClock.sv
      - flacSubframe_asserts.sv
      - tbFlacSubframe.sv
